// ==== mem_stage_vectors.txt ====
// kind instr addr data ovr expected aux, kind 0 store 1 load 2 flush 3 stall, ffffffff ends
// aux[7:4] is the expected we mask, aux[2:0] the op1/op2/csr overwrite enables
0 0020A023 00000100 11223344 00000000 11223344 f0
0 00208023 00000100 00000055 00000000 55555555 10
0 00208023 00000101 000000AB 00000000 ABABABAB 20
0 00208023 00000102 00000077 00000000 77777777 40
0 00208023 00000103 FFFFFFCD 00000000 CDCDCDCD 80
1 0000A283 00000100 00000000 00000000 CD77AB55 00
0 0020A023 00000104 A5A5A5A5 00000000 A5A5A5A5 f0
0 00209023 00000104 00001234 00000000 12341234 30
0 00209023 00000106 FFFF9876 00000000 98769876 c0
1 0000A503 00000104 00000000 00000000 98761234 00
0 0020A023 00000108 DEADBEEF 00000000 DEADBEEF f0
1 0000A383 00000108 00000000 00000000 DEADBEEF 00
// load extension words
0 0020A023 00000040 8081F27F 00000000 8081F27F f0
0 0020A023 00000044 7FFF0180 00000000 7FFF0180 f0
1 00008283 00000040 00000000 00000000 0000007F 00
1 00008283 00000041 00000000 00000000 FFFFFFF2 00
1 00008283 00000042 00000000 00000000 FFFFFF81 00
1 00008283 00000043 00000000 00000000 FFFFFF80 00
1 0000C303 00000040 00000000 00000000 0000007F 00
1 0000C303 00000041 00000000 00000000 000000F2 00
1 0000C303 00000042 00000000 00000000 00000081 00
1 0000C303 00000043 00000000 00000000 00000080 00
1 00009403 00000040 00000000 00000000 FFFFF27F 00
1 00009403 00000042 00000000 00000000 FFFF8081 00
1 00009403 00000044 00000000 00000000 00000180 00
1 00009403 00000046 00000000 00000000 00007FFF 00
1 0000D483 00000040 00000000 00000000 0000F27F 00
1 0000D483 00000042 00000000 00000000 00008081 00
1 00008F83 00000044 00000000 00000000 FFFFFF80 00
1 00008F83 00000045 00000000 00000000 00000001 00
1 0000A283 00000040 00000000 00000000 8081F27F 00
2 0000A283 00000040 00000000 00000000 00000000 00
// stalled stores with forwarding fix-ups
3 0020A023 00000200 01020304 CAFEF00D CAFEF00D f7
3 0020A023 00000204 01020304 CAFEF00D 01020304 f5
3 0020A023 00000208 55667788 12345678 12345678 f2
1 0000A283 00000200 00000000 00000000 CAFEF00D 00
1 0000A283 00000204 00000000 00000000 01020304 00
3 00208023 00000209 00000011 000000EE EEEEEEEE 22
1 0000A283 00000208 00000000 00000000 1234EE78 00
FFFFFFFF 0 0 0 0 0 0

// ==== flist.f ====
mem_stage_pkg.sv
pipe_stage_reg.sv
data_mem_port.sv
load_align.sv
mem_stage_top.sv
tb_mem_stage.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the memory stage testbench with verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f flist.f --top-module tb_mem_stage -Mdir obj_dir -o sim_mem_stage
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

output=$(./obj_dir/sim_mem_stage)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if echo "$output" | grep -qx "sim passed"; then
   exit 0
fi
exit 1

// ==== tb_mem_stage.sv ====
`timescale 1ns/1ns

module tb_mem_stage;

   localparam int max_tests = 64;
   localparam mem_stage_pkg::word_t op_store = 32'h0;
   localparam mem_stage_pkg::word_t op_load  = 32'h1;
   localparam mem_stage_pkg::word_t op_flush = 32'h2;
   localparam mem_stage_pkg::word_t op_stall = 32'h3;
   localparam mem_stage_pkg::word_t op_end   = 32'hffff_ffff;

   logic                         clk;
   logic                         reset;
   logic                         i_flush;
   logic                         i_en;
   mem_stage_pkg::stage_fields_t i_fields;
   mem_stage_pkg::overwrite_t    i_ovr;
   mem_stage_pkg::word_t         i_mem_rdata;
   mem_stage_pkg::stage_fields_t o_fields;
   mem_stage_pkg::mem_req_t      o_mem_req;
   mem_stage_pkg::load_res_t     o_load;

   mem_stage_pkg::word_t ram [0:255];
   // seven words per test
   mem_stage_pkg::word_t vec [0:max_tests*7-1];
   int num_tests;
   int tests_run;
   int tests_failed;
   int mismatches;
   bit test_fail;
   bit vectors_loaded;

   mem_stage_top #(
      .rst_instr(mem_stage_pkg::nop_instr)
   ) uut (
      .clk         (clk),
      .reset       (reset),
      .i_flush     (i_flush),
      .i_en        (i_en),
      .i_fields    (i_fields),
      .i_ovr       (i_ovr),
      .i_mem_rdata (i_mem_rdata),
      .o_fields    (o_fields),
      .o_mem_req   (o_mem_req),
      .o_load      (o_load)
   );

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   // block ram model, old word comes back next cycle
   initial begin
      for (int a = 0; a < 256; a++) begin
         ram[a] = mem_stage_pkg::word_t'(a) * 32'h0100_0193 ^ 32'h811c_9dc5;
      end
      i_mem_rdata <= '0;
      forever begin
         @(posedge clk);
         if (o_mem_req.en) begin
            i_mem_rdata <= ram[o_mem_req.addr[9:2]];
            if (o_mem_req.we[0]) ram[o_mem_req.addr[9:2]][7:0] = o_mem_req.wdata[7:0];
            if (o_mem_req.we[1]) ram[o_mem_req.addr[9:2]][15:8] = o_mem_req.wdata[15:8];
            if (o_mem_req.we[2]) ram[o_mem_req.addr[9:2]][23:16] = o_mem_req.wdata[23:16];
            if (o_mem_req.we[3]) ram[o_mem_req.addr[9:2]][31:24] = o_mem_req.wdata[31:24];
         end
      end
   end

   initial begin
      wait (vectors_loaded);
      repeat ((num_tests + 1) * 20) @(posedge clk);
      $display("watchdog: tests did not finish within %0d cycles", (num_tests + 1) * 20);
      $display("sim failed");
      $finish;
   end

   function automatic mem_stage_pkg::stage_fields_t bubble_fields();
      mem_stage_pkg::stage_fields_t f;
      f = '0;
      f.instr.raw = mem_stage_pkg::nop_instr;
      f.bubble = 1'b1;
      return f;
   endfunction

   function automatic mem_stage_pkg::stage_fields_t make_fields(
      input mem_stage_pkg::word_t kind, instr, addr, data);
      mem_stage_pkg::stage_fields_t f;
      f = '0;
      f.pc = $urandom;
      f.instr.raw = instr;
      f.alu_res = addr;
      f.ld_ready = (kind == op_load || kind == op_flush);
      f.sd_ready = (kind == op_store || kind == op_stall);
      f.load_reg = f.ld_ready;
      f.reg_write_en = f.ld_ready;
      f.rd = instr[11:7];
      f.op_rs1 = instr[19:15];
      f.op_rs2 = instr[24:20];
      f.op1 = addr;
      f.op2 = data;
      f.rd_data = $urandom;
      f.csr_reg = mem_stage_pkg::csr_addr_t'($urandom);
      f.csr_val = $urandom;
      return f;
   endfunction

   task automatic check_fields(input mem_stage_pkg::stage_fields_t got, exp);
      if (got !== exp) begin
         $display("ERROR o_fields got %h expected %h", got, exp);
         mismatches++;
         test_fail = 1'b1;
      end
   endtask

   task automatic check_req(input mem_stage_pkg::mem_req_t got, exp);
      if (got !== exp) begin
         $display("ERROR o_mem_req got %h expected %h", got, exp);
         mismatches++;
         test_fail = 1'b1;
      end
   endtask

   // rd and data only matter when valid is expected
   task automatic check_load(input mem_stage_pkg::load_res_t got, exp);
      if (got.valid !== exp.valid || (exp.valid && (got.rd !== exp.rd || got.data !== exp.data)))
      begin
         $display("ERROR o_load valid/rd/data got %h/%h/%h expected %h/%h/%h",
                  got.valid, got.rd, got.data, exp.valid, exp.rd, exp.data);
         mismatches++;
         test_fail = 1'b1;
      end
   endtask

   task automatic finish_test(input string what);
      tests_run++;
      if (test_fail) begin
         tests_failed++;
         $display("test %0d %s: FAIL", tests_run, what);
      end else begin
         $display("test %0d %s: ok", tests_run, what);
      end
      test_fail = 1'b0;
   endtask

   // capture edge first, then the cycle that holds the stage
   task automatic issue(input mem_stage_pkg::stage_fields_t f, input logic flush,
                        input logic stall, input mem_stage_pkg::overwrite_t ov);
      @(posedge clk);
      i_fields <= f;
      i_en <= 1'b1;
      i_flush <= flush;
      @(posedge clk);
      i_fields <= '0;
      i_flush <= 1'b0;
      i_en <= !stall;
      i_ovr <= ov;
      @(negedge clk);
   endtask

   task automatic run_vector(input int n);
      mem_stage_pkg::word_t kind, instr, addr, data, ovr, expv, aux;
      mem_stage_pkg::stage_fields_t f;
      mem_stage_pkg::mem_req_t req;
      mem_stage_pkg::load_res_t ld;
      mem_stage_pkg::overwrite_t ov;
      kind = vec[n*7];
      instr = vec[n*7+1];
      addr = vec[n*7+2];
      data = vec[n*7+3];
      ovr = vec[n*7+4];
      expv = vec[n*7+5];
      aux = vec[n*7+6];
      f = make_fields(kind, instr, addr, data);
      req = '{en: 1'b1, we: aux[7:4], addr: {addr[31:2], 2'b00}, wdata: expv};
      ld = '{valid: 1'b1, rd: instr[11:7], data: expv};
      ov = '{op1_en: aux[0], op1: {ovr[15:0], ovr[31:16]}, op2_en: aux[1], op2: ovr,
             csr_en: aux[2], csr_val: ~ovr};
      case (kind)
         op_store: begin
            issue(f, 1'b0, 1'b0, '0);
            check_req(o_mem_req, req);
            finish_test($sformatf("store %h at %h", data, addr));
         end
         op_load: begin
            req.wdata = '0;
            issue(f, 1'b0, 1'b0, '0);
            check_req(o_mem_req, req);
            check_load(o_load, '0);
            @(negedge clk);
            check_load(o_load, ld);
            finish_test($sformatf("load %h at %h", instr, addr));
         end
         op_flush: begin
            issue(f, 1'b1, 1'b0, '0);
            check_fields(o_fields, bubble_fields());
            check_req(o_mem_req, '0);
            @(negedge clk);
            check_load(o_load, '0);
            finish_test($sformatf("flush of load at %h", addr));
         end
         op_stall: begin
            issue(f, 1'b0, 1'b1, ov);
            @(posedge clk);
            i_ovr <= '0;
            @(negedge clk);
            if (ov.op1_en) f.op1 = ov.op1;
            if (ov.op2_en) f.op2 = ov.op2;
            if (ov.csr_en) f.csr_val = ov.csr_val;
            check_fields(o_fields, f);
            check_req(o_mem_req, req);
            @(posedge clk);
            i_en <= 1'b1;
            finish_test($sformatf("stall overwrite at %h", addr));
         end
         default: begin
            $display("vector %0d has an unknown operation kind %h", n, kind);
            mismatches++;
            test_fail = 1'b1;
            finish_test("bad vector");
         end
      endcase
   endtask

   initial begin
      reset <= 1'b1;
      i_en <= 1'b0;
      i_flush <= 1'b0;
      i_fields <= '0;
      i_ovr <= '0;
      void'($urandom(32'he837));
      $readmemh("mem_stage_vectors.txt", vec);
      while (num_tests < max_tests && vec[num_tests*7] != op_end) begin
         num_tests++;
      end
      vectors_loaded = 1'b1;
      repeat (10) @(posedge clk);
      reset <= 1'b0;
      @(negedge clk);
      check_fields(o_fields, bubble_fields());
      check_req(o_mem_req, '0);
      check_load(o_load, '0);
      finish_test("reset state");
      for (int n = 0; n < num_tests; n++) begin
         run_vector(n);
      end
      $display("%0d tests run, %0d failed, %0d mismatches", tests_run, tests_failed, mismatches);
      if (tests_failed == 0) begin
         $display("sim passed");
      end else begin
         $display("sim failed");
      end
      $finish;
   end

endmodule

// ==== mem_stage_top.sv ====
`timescale 1ns/1ns

module mem_stage_top #(
   parameter mem_stage_pkg::word_t rst_instr = mem_stage_pkg::nop_instr
) (
   input  logic                         clk,
   input  logic                         reset,
   input  logic                         i_flush,
   input  logic                         i_en,
   input  mem_stage_pkg::stage_fields_t i_fields,
   input  mem_stage_pkg::overwrite_t    i_ovr,
   input  mem_stage_pkg::word_t         i_mem_rdata,
   output mem_stage_pkg::stage_fields_t o_fields,
   output mem_stage_pkg::mem_req_t      o_mem_req,
   output mem_stage_pkg::load_res_t     o_load
);

   mem_stage_pkg::stage_fields_t stage_q;
   mem_stage_pkg::funct3_t       rd_funct3;
   mem_stage_pkg::reg_idx_t      rd_idx;
   logic [1:0]                   rd_offset;
   logic                         rd_valid;

   pipe_stage_reg #(
      .rst_instr(rst_instr)
   ) u_stage_reg (
      .clk      (clk),
      .reset    (reset),
      .i_flush  (i_flush),
      .i_en     (i_en),
      .i_fields (i_fields),
      .i_ovr    (i_ovr),
      .o_fields (stage_q)
   );

   assign o_fields = stage_q;

   data_mem_port u_mem_port (
      .clk        (clk),
      .reset      (reset),
      .i_fields   (stage_q),
      .o_mem_req  (o_mem_req),
      .o_rd_valid (rd_valid),
      .o_funct3   (rd_funct3),
      .o_offset   (rd_offset),
      .o_rd       (rd_idx)
   );

   // result lands one cycle after the request
   load_align u_load_align (
      .i_rd_valid  (rd_valid),
      .i_funct3    (rd_funct3),
      .i_offset    (rd_offset),
      .i_rd        (rd_idx),
      .i_mem_rdata (i_mem_rdata),
      .o_load      (o_load)
   );

endmodule

// ==== load_align.sv ====
`timescale 1ns/1ns

module load_align (
   input  logic                     i_rd_valid,
   input  mem_stage_pkg::funct3_t   i_funct3,
   input  logic [1:0]               i_offset,
   input  mem_stage_pkg::reg_idx_t  i_rd,
   input  mem_stage_pkg::word_t     i_mem_rdata,
   output mem_stage_pkg::load_res_t o_load
);

   logic [7:0]  byte_sel;
   logic [15:0] half_sel;

   // lane pick by low address bits
   always_comb begin
      case (i_offset)
         2'd0: byte_sel = i_mem_rdata[7:0];
         2'd1: byte_sel = i_mem_rdata[15:8];
         2'd2: byte_sel = i_mem_rdata[23:16];
         default: byte_sel = i_mem_rdata[31:24];
      endcase
   end

   assign half_sel = i_offset[1] ? i_mem_rdata[31:16] : i_mem_rdata[15:0];

   always_comb begin
      o_load.valid = i_rd_valid;
      o_load.rd    = i_rd;
      case (i_funct3)
         mem_stage_pkg::f3_byte: begin
            o_load.data = {{24{byte_sel[7]}}, byte_sel};
         end
         mem_stage_pkg::f3_half: begin
            o_load.data = {{16{half_sel[15]}}, half_sel};
         end
         mem_stage_pkg::f3_byte_u: begin
            o_load.data = {24'd0, byte_sel};
         end
         mem_stage_pkg::f3_half_u: begin
            o_load.data = {16'd0, half_sel};
         end
         mem_stage_pkg::f3_word: begin
            o_load.data = i_mem_rdata;
         end
         default: begin
            // reserved codes, pass the word
            o_load.data = i_mem_rdata;
         end
      endcase
   end

endmodule

// ==== data_mem_port.sv ====
`timescale 1ns/1ns

module data_mem_port (
   input  logic                         clk,
   input  logic                         reset,
   input  mem_stage_pkg::stage_fields_t i_fields,
   output mem_stage_pkg::mem_req_t      o_mem_req,
   output logic                         o_rd_valid,
   output mem_stage_pkg::funct3_t       o_funct3,
   output logic [1:0]                   o_offset,
   output mem_stage_pkg::reg_idx_t      o_rd
);

   mem_stage_pkg::itype_t i_view;
   mem_stage_pkg::stype_t s_view;
   mem_stage_pkg::be_t    width_mask;
   mem_stage_pkg::word_t  lane_data;
   logic [1:0]            offset;
   logic                  access;
   logic                  is_store;

   assign i_view   = i_fields.instr.i;
   assign s_view   = i_fields.instr.s;
   assign offset   = i_fields.alu_res[1:0];
   assign access   = !i_fields.bubble && (i_fields.ld_ready || i_fields.sd_ready);
   assign is_store = access && i_fields.sd_ready;

   // byte mask and lane copy by store width
   always_comb begin
      case (s_view.funct3)
         mem_stage_pkg::f3_byte: begin
            width_mask = 4'b0001;
            lane_data  = {4{i_fields.op2[7:0]}};
         end
         mem_stage_pkg::f3_half: begin
            width_mask = 4'b0011;
            lane_data  = {2{i_fields.op2[15:0]}};
         end
         default: begin
            width_mask = 4'b1111;
            lane_data  = i_fields.op2;
         end
      endcase
   end

   assign o_mem_req.en    = access;
   assign o_mem_req.we    = is_store ? mem_stage_pkg::be_t'(width_mask << offset) : '0;
   assign o_mem_req.addr  = {i_fields.alu_res[31:2], 2'b00};
   assign o_mem_req.wdata = lane_data;

   // ram answers one cycle after the request
   always_ff @(posedge clk) begin
      if (reset) begin
         o_rd_valid <= 1'b0;
      end else begin
         o_rd_valid <= access && !is_store;
      end
   end

   always_ff @(posedge clk) begin
      o_funct3 <= i_view.funct3;
      o_offset <= offset;
      o_rd     <= i_view.rd;
   end

endmodule

// ==== pipe_stage_reg.sv ====
`timescale 1ns/1ns

module pipe_stage_reg #(
   parameter mem_stage_pkg::word_t rst_instr = mem_stage_pkg::nop_instr
) (
   input  logic                         clk,
   input  logic                         reset,
   input  logic                         i_flush,
   input  logic                         i_en,
   input  mem_stage_pkg::stage_fields_t i_fields,
   input  mem_stage_pkg::overwrite_t    i_ovr,
   output mem_stage_pkg::stage_fields_t o_fields
);

   mem_stage_pkg::stage_fields_t q;
   mem_stage_pkg::stage_fields_t bubble_val;
   mem_stage_pkg::stage_fields_t din;

   // empty slot, everything zero except the nop word
   always_comb begin
      bubble_val = '0;
      bubble_val.instr.raw = rst_instr;
      bubble_val.bubble = 1'b1;
   end

   // a captured instruction is never a bubble
   always_comb begin
      din = i_fields;
      din.bubble = 1'b0;
   end

   always_ff @(posedge clk) begin
      if (reset || i_flush) begin
         q <= bubble_val;
      end else if (i_en) begin
         q <= din;
      end else begin
         // stalled, only patch forwarded values
         if (i_ovr.op1_en) begin
            q.op1 <= i_ovr.op1;
         end
         if (i_ovr.op2_en) begin
            q.op2 <= i_ovr.op2;
         end
         if (i_ovr.csr_en) begin
            q.csr_val <= i_ovr.csr_val;
         end
      end
   end

   assign o_fields = q;

endmodule

// ==== mem_stage_pkg.sv ====
package mem_stage_pkg;

   localparam int xlen = 32;

   typedef logic [xlen-1:0] word_t;
   typedef logic [4:0]      reg_idx_t;
   typedef logic [11:0]     csr_addr_t;
   typedef logic [3:0]      be_t;
   typedef logic [2:0]      funct3_t;

   // addi x0,x0,0
   localparam word_t nop_instr = 32'h0000_0013;

   // load/store width and sign codes
   localparam funct3_t f3_byte   = 3'b000;
   localparam funct3_t f3_half   = 3'b001;
   localparam funct3_t f3_word   = 3'b010;
   localparam funct3_t f3_byte_u = 3'b100;
   localparam funct3_t f3_half_u = 3'b101;

   // load view
   typedef struct packed {
      logic [11:0] imm;
      reg_idx_t    rs1;
      funct3_t     funct3;
      reg_idx_t    rd;
      logic [6:0]  opcode;
   } itype_t;

   // store view
   typedef struct packed {
      logic [6:0] imm_hi;
      reg_idx_t   rs2;
      reg_idx_t   rs1;
      funct3_t    funct3;
      logic [4:0] imm_lo;
      logic [6:0] opcode;
   } stype_t;

   typedef union packed {
      word_t  raw;
      itype_t i;
      stype_t s;
   } instr_u;

   typedef struct packed {
      word_t     pc;
      instr_u    instr;
      // effective address
      word_t     alu_res;
      logic      csr_write_en;
      logic      load_reg;
      logic      reg_write_en;
      logic      ld_ready;
      logic      sd_ready;
      reg_idx_t  rd;
      reg_idx_t  op_rs1;
      reg_idx_t  op_rs2;
      word_t     op1;
      word_t     op2;
      word_t     immediate;
      word_t     rd_data;
      csr_addr_t csr_reg;
      word_t     csr_val;
      logic      bubble;
   } stage_fields_t;

   // forwarding fix-ups into a stalled stage
   typedef struct packed {
      logic  op1_en;
      word_t op1;
      logic  op2_en;
      word_t op2;
      logic  csr_en;
      word_t csr_val;
   } overwrite_t;

   typedef struct packed {
      logic  en;
      be_t   we;
      word_t addr;
      word_t wdata;
   } mem_req_t;

   typedef struct packed {
      logic     valid;
      reg_idx_t rd;
      word_t    data;
   } load_res_t;

endpackage
